/* Makefile */
# Verilator build and run for the execute block testbench.

VERILATOR ?= verilator
TOP       ?= tbExecCore
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= RESULT: PASS

SOURCES := $(wildcard logic/*.sv tests/*.sv tests/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation log shows a pass."; \
	else \
		echo "Simulation log shows no pass."; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* logic/aluUnit.sv */
`timescale 1ns/1ps

module aluUnit import execPkg::*; (
    input  ctrl_t             ctrl,
    input  logic [DATA_W-1:0] rd1,
    input  logic [DATA_W-1:0] rd2,
    output logic [DATA_W-1:0] result,
    output logic [DATA_W-1:0] nFlag
);

    logic [DATA_W-1:0] opB;
    logic [DATA_W:0]   sum;
    logic              carry;
    logic              ovf;

    assign opB = ctrl.useImm ? ctrl.imm : rd2;

    always_comb begin
        sum    = '0;
        carry  = 1'b0;
        ovf    = 1'b0;
        result = '0;

        case (ctrl.aluOp)
            ALU_ADD: begin
                sum    = {1'b0, rd1} + {1'b0, opB};
                result = sum[DATA_W-1:0];
                carry  = sum[DATA_W];
                ovf    = (rd1[DATA_W-1] == opB[DATA_W-1]) &&
                         (result[DATA_W-1] != rd1[DATA_W-1]);
            end
            ALU_SUB: begin
                sum    = {1'b0, rd1} - {1'b0, opB};
                result = sum[DATA_W-1:0];
                carry  = sum[DATA_W];  // Borrow, set when rd1 < opB unsigned.
                ovf    = (rd1[DATA_W-1] != opB[DATA_W-1]) &&
                         (result[DATA_W-1] != rd1[DATA_W-1]);
            end
            ALU_AND: result = rd1 & opB;
            ALU_OR:  result = rd1 | opB;
            ALU_XOR: result = rd1 ^ opB;
            ALU_SHL: result = rd1 << opB[4:0];
            default: result = '0;
        endcase
    end

    always_comb begin
        nFlag         = '0;
        nFlag[FLAG_Z] = (result == '0);
        nFlag[FLAG_N] = result[DATA_W-1];
        nFlag[FLAG_C] = carry;
        nFlag[FLAG_V] = ovf;
    end

endmodule

/* logic/execCore.sv */
`timescale 1ns/1ps

module execCore import execPkg::*; (
    input  logic              clk,
    input  logic              rstN,
    input  logic              issue,
    input  instrWord_u        instr,
    output logic [DATA_W-1:0] result,
    output logic [DATA_W-1:0] flag
);

    ctrl_t             ctrl;
    logic [DATA_W-1:0] rd1;
    logic [DATA_W-1:0] rd2;
    logic [DATA_W-1:0] nFlag;

    instrDecoder u_decoder (
        .instr (instr),
        .issue (issue),
        .ctrl  (ctrl)
    );

    gprFile u_gpr (
        .clk    (clk),
        .rstN   (rstN),
        .we     (ctrl.we),
        .flagOp (ctrl.flagOp),
        .a1     (ctrl.a1),
        .a2     (ctrl.a2),
        .aWr    (ctrl.aWr),
        .din    (result),     // Written back at the issuing edge.
        .nFlag  (nFlag),
        .rd1    (rd1),
        .rd2    (rd2),
        .flag   (flag)
    );

    aluUnit u_alu (
        .ctrl   (ctrl),
        .rd1    (rd1),
        .rd2    (rd2),
        .result (result),
        .nFlag  (nFlag)
    );

endmodule

/* logic/execPkg.sv */
package execPkg;

    localparam int DATA_W = 32;
    localparam int REG_COUNT = 32;
    localparam int REG_ADDR_W = $clog2(REG_COUNT);
    localparam logic [REG_ADDR_W-1:0] REG_ADDR_FLAG = REG_ADDR_W'(REG_COUNT - 1);

    // Bit positions inside the flag word.
    localparam int FLAG_Z = 0;
    localparam int FLAG_N = 1;
    localparam int FLAG_C = 2;
    localparam int FLAG_V = 3;

    typedef enum logic [5:0] {
        OP_ADD  = 6'h01,
        OP_SUB  = 6'h02,
        OP_AND  = 6'h03,
        OP_OR   = 6'h04,
        OP_XOR  = 6'h05,
        OP_SHL  = 6'h06,
        OP_CMP  = 6'h07,
        OP_ADDF = 6'h08,
        OP_ADDI = 6'h10,  // Immediate forms start here.
        OP_ORI  = 6'h11
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SHL = 3'd5
    } aluOp_e;

    typedef enum logic [1:0] {
        FLAG_OP_DIS        = 2'b00,
        FLAG_OP_SET        = 2'b01,
        FLAG_OP_SET_AND_WR = 2'b10
    } flagOp_e;

    typedef struct packed {
        opcode_e               opcode;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [10:0]           unused;
    } rType_t;

    typedef struct packed {
        opcode_e               opcode;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [15:0]           imm;  // Sign-extended on use.
    } iType_t;

    typedef union packed {
        rType_t r;
        iType_t i;
    } instrWord_u;

    typedef struct packed {
        logic [REG_ADDR_W-1:0] a1;
        logic [REG_ADDR_W-1:0] a2;
        logic [REG_ADDR_W-1:0] aWr;
        logic                  useImm;
        logic [DATA_W-1:0]     imm;
        aluOp_e                aluOp;
        logic                  we;
        flagOp_e               flagOp;
    } ctrl_t;

endpackage

/* logic/gprFile.sv */
`timescale 1ns/1ps

module gprFile import execPkg::*; (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  we,
    input  flagOp_e               flagOp,
    input  logic [REG_ADDR_W-1:0] a1,
    input  logic [REG_ADDR_W-1:0] a2,
    input  logic [REG_ADDR_W-1:0] aWr,
    input  logic [DATA_W-1:0]     din,
    input  logic [DATA_W-1:0]     nFlag,
    output logic [DATA_W-1:0]     rd1,
    output logic [DATA_W-1:0]     rd2,
    output logic [DATA_W-1:0]     flag
);

    // Storage for r1..r30; r0 is hardwired, r31 maps to the flag word.
    logic [DATA_W-1:0] regs [1:REG_COUNT-2];
    logic [DATA_W-1:0] flagReg;
    logic              flagLoad;
    logic              regWr;

    function automatic logic [DATA_W-1:0] readPort(input logic [REG_ADDR_W-1:0] a);
        logic [DATA_W-1:0] val;
        if (a == '0) begin
            val = '0;
        end else if (a == REG_ADDR_FLAG) begin
            val = flagReg;
        end else begin
            val = regs[a];
        end
        return val;
    endfunction

    always_comb begin
        rd1 = readPort(a1);
        rd2 = readPort(a2);
    end

    assign flagLoad = (flagOp == FLAG_OP_SET) || (flagOp == FLAG_OP_SET_AND_WR);
    assign regWr    = we && (aWr != '0) && (aWr != REG_ADDR_FLAG);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 1; i < REG_COUNT - 1; i++) begin
                regs[i] <= '0;
            end
        end else if (regWr) begin
            regs[aWr] <= din;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            flagReg <= '0;
        end else if (flagLoad) begin
            flagReg <= nFlag;                  // ALU flags beat a direct write.
        end else if (we && aWr == REG_ADDR_FLAG) begin
            flagReg <= din;
        end
    end

    assign flag = flagReg;

endmodule

/* logic/instrDecoder.sv */
`timescale 1ns/1ps

module instrDecoder import execPkg::*; (
    input  instrWord_u instr,
    input  logic       issue,
    output ctrl_t      ctrl
);

    localparam int IMM_W = $bits(instr.i.imm);

    always_comb begin
        ctrl        = '0;
        ctrl.a1     = instr.r.rs1;    // Same position in both views.
        ctrl.aWr    = instr.r.rd;
        ctrl.imm    = {{(DATA_W-IMM_W){instr.i.imm[IMM_W-1]}}, instr.i.imm};
        ctrl.aluOp  = ALU_ADD;
        ctrl.flagOp = FLAG_OP_DIS;

        case (instr.r.opcode)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHL, OP_ADDF: begin
                ctrl.a2 = instr.r.rs2;
                ctrl.we = 1'b1;
            end
            OP_CMP: begin
                ctrl.a2 = instr.r.rs2;  // Compare only, no register write.
            end
            OP_ADDI, OP_ORI: begin
                ctrl.useImm = 1'b1;
                ctrl.we     = 1'b1;
            end
            default: ;                  // Unknown opcode is a no-op.
        endcase

        case (instr.r.opcode)
            OP_SUB, OP_CMP: ctrl.aluOp = ALU_SUB;
            OP_AND:         ctrl.aluOp = ALU_AND;
            OP_OR, OP_ORI:  ctrl.aluOp = ALU_OR;
            OP_XOR:         ctrl.aluOp = ALU_XOR;
            OP_SHL:         ctrl.aluOp = ALU_SHL;
            default:        ctrl.aluOp = ALU_ADD;
        endcase

        if (instr.r.opcode == OP_CMP) begin
            ctrl.flagOp = FLAG_OP_SET;
        end else if (instr.r.opcode == OP_ADDF) begin
            ctrl.flagOp = FLAG_OP_SET_AND_WR;
        end

        // Without a strobe nothing may change state.
        if (!issue) begin
            ctrl.we     = 1'b0;
            ctrl.flagOp = FLAG_OP_DIS;
        end
    end

endmodule

/* tb.f */
+incdir+tests
logic/execPkg.sv
logic/instrDecoder.sv
logic/aluUnit.sv
logic/gprFile.sv
logic/execCore.sv
tests/tbExecCore.sv

/* tests/execModel.svh */
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

logic [DATA_W-1:0] modelRegs [0:REG_COUNT-1] = '{default: '0};
logic [DATA_W-1:0] modelFlag = '0;

function automatic logic [DATA_W-1:0] modelRead(input logic [REG_ADDR_W-1:0] a);
    if (a == '0) begin
        return '0;
    end
    if (a == REG_ADDR_FLAG) begin
        return modelFlag;  // Flag word sits at the top address.
    end
    return modelRegs[a];
endfunction

// Expected result now and flag word after the edge; commits state when issued.
function automatic void predict(input instrWord_u ins, input logic iss,
                                output logic [DATA_W-1:0] expRes,
                                output logic [DATA_W-1:0] expFlag);
    opcode_e           op;
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    logic [DATA_W-1:0] res;
    logic [DATA_W-1:0] nf;
    logic              c;
    logic              v;
    logic              wrReg;
    logic              setFlag;
    op      = ins.r.opcode;
    a       = modelRead(ins.r.rs1);
    b       = (op == OP_ADDI || op == OP_ORI) ? {{16{ins.i.imm[15]}}, ins.i.imm}
                                              : modelRead(ins.r.rs2);
    res     = '0;
    c       = 1'b0;
    v       = 1'b0;
    wrReg   = (op != OP_CMP);
    setFlag = (op == OP_CMP) || (op == OP_ADDF);
    case (op)
        OP_ADD, OP_ADDF, OP_ADDI: begin
            res = a + b;
            c   = res < a;  // Unsigned wrap.
            v   = (longint'($signed(a)) + longint'($signed(b))) != longint'($signed(res));
        end
        OP_SUB, OP_CMP: begin
            res = a - b;
            c   = a < b;    // Borrow.
            v   = (longint'($signed(a)) - longint'($signed(b))) != longint'($signed(res));
        end
        OP_AND:        res = a & b;
        OP_OR, OP_ORI: res = a | b;
        OP_XOR:        res = a ^ b;
        OP_SHL:        res = a << b[4:0];
        default:       wrReg = 1'b0;
    endcase
    nf         = '0;
    nf[FLAG_Z] = (res == '0);
    nf[FLAG_N] = res[DATA_W-1];
    nf[FLAG_C] = c;
    nf[FLAG_V] = v;
    expRes     = res;
    if (iss) begin
        if (setFlag) begin
            modelFlag = nf;
        end else if (wrReg && ins.r.rd == REG_ADDR_FLAG) begin
            modelFlag = res;
        end
        if (wrReg && ins.r.rd != '0 && ins.r.rd != REG_ADDR_FLAG) begin
            modelRegs[ins.r.rd] = res;
        end
    end
    expFlag = modelFlag;
endfunction

`endif

/* tests/tbExecCore.sv */
`timescale 1ns/1ps

module tbExecCore import execPkg::*; ();

    localparam int RESET_CYCLES   = 2;
    localparam int DIRECTED_STEPS = 62;
    localparam int RANDOM_STEPS   = 400;
    localparam int CYCLE_LIMIT    = RESET_CYCLES + DIRECTED_STEPS + RANDOM_STEPS + 1 + 50;

    logic              clk;
    logic              rstN;
    logic              issue;
    instrWord_u        instr;
    logic [DATA_W-1:0] result;
    logic [DATA_W-1:0] flag;

    int                directErrs = 0;
    int                cmpErrs = 0;
    int                testsFailed = 0;
    int                cycles = 0;
    opcode_e           opTable [10];
    logic [DATA_W-1:0] expResult;
    logic [DATA_W-1:0] expNextFlag;
    logic [DATA_W-1:0] pendingFlag = '0;
    event              compared;

    `include "execModel.svh"

    execCore u_dut (
        .clk    (clk),
        .rstN   (rstN),
        .issue  (issue),
        .instr  (instr),
        .result (result),
        .flag   (flag)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic instrWord_u makeRType(input opcode_e op, input int rd, input int rs1,
                                             input int rs2);
        instrWord_u w;
        w.r.opcode = op;
        w.r.rd     = 5'(rd);
        w.r.rs1    = 5'(rs1);
        w.r.rs2    = 5'(rs2);
        w.r.unused = '0;
        return w;
    endfunction

    function automatic instrWord_u makeIType(input opcode_e op, input int rd, input int rs1,
                                             input logic [15:0] imm);
        instrWord_u w;
        w.i.opcode = op;
        w.i.rd     = 5'(rd);
        w.i.rs1    = 5'(rs1);
        w.i.imm    = imm;
        return w;
    endfunction

    function automatic int mismatch(input string sig, input logic [DATA_W-1:0] got,
                                    input logic [DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("** Error at time %0t: %s expected %h, got %h", $time, sig, exp, got);
            return 1;
        end
        return 0;
    endfunction

    task automatic expectEq(input string sig, input logic [DATA_W-1:0] got,
                            input logic [DATA_W-1:0] exp);
        directErrs += mismatch(sig, got, exp);
    endtask

    // Drive on the rising edge, return once the falling-edge comparison has run.
    task automatic step(input instrWord_u ins, input logic iss);
        @(posedge clk);
        issue <= iss;
        instr <= ins;
        @(compared);
    endtask

    task automatic finishTest(input string name, input int errsBefore);
        int errs;
        errs = directErrs + cmpErrs - errsBefore;
        if (errs == 0) begin
            $display("Test %s: passed", name);
        end else begin
            testsFailed++;
            $display("Test %s: failed with %0d errors", name, errs);
        end
    endtask

    // Model comparison on every settled cycle.
    always @(negedge clk) begin
        if (rstN) begin
            predict(instr, issue, expResult, expNextFlag);
            cmpErrs += mismatch("result", result, expResult);
            cmpErrs += mismatch("flag", flag, pendingFlag);
            pendingFlag = expNextFlag;
        end
        -> compared;
    end

    initial begin
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        int         base;
        int         n;
        opcode_e    op;
        instrWord_u w;
        void'($urandom(92768));
        opTable = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHL, OP_CMP, OP_ADDF,
                    OP_ADDI, OP_ORI};
        rstN  = 1'b0;
        issue = 1'b0;
        instr = makeRType(OP_OR, 0, 0, 0);
        repeat (RESET_CYCLES) @(posedge clk);
        rstN <= 1'b1;

        base = directErrs + cmpErrs;
        for (n = 0; n < 31; n++) begin
            step(makeRType(OP_OR, n, n, 0), 1'b1);
            expectEq("result", result, '0);
        end
        step(makeRType(OP_OR, 0, 0, 0), 1'b0);
        expectEq("flag", flag, '0);
        finishTest("reset state", base);

        base = directErrs + cmpErrs;
        step(makeIType(OP_ADDI, 5, 0, 16'h1234), 1'b1);
        expectEq("result", result, 32'h0000_1234);
        repeat (3) step(makeIType(OP_ADDI, 5, 0, 16'h7777), 1'b0);  // Must not land.
        step(makeRType(OP_OR, 6, 5, 0), 1'b1);
        expectEq("result", result, 32'h0000_1234);
        step(makeIType(OP_ADDI, 7, 0, 16'hFFFE), 1'b1);
        expectEq("result", result, 32'hFFFF_FFFE);
        step(makeRType(OP_OR, 8, 7, 0), 1'b1);
        expectEq("result", result, 32'hFFFF_FFFE);
        finishTest("write and read back", base);

        base = directErrs + cmpErrs;
        step(makeIType(OP_ADDI, 0, 0, 16'h0055), 1'b1);
        expectEq("result", result, 32'h0000_0055);
        step(makeRType(OP_OR, 1, 0, 0), 1'b1);
        expectEq("result", result, '0);
        finishTest("register zero", base);

        base = directErrs + cmpErrs;
        step(makeIType(OP_ADDI, 1, 0, 16'd5), 1'b1);
        step(makeIType(OP_ADDI, 2, 0, 16'd7), 1'b1);
        step(makeIType(OP_ADDI, 3, 0, 16'd9), 1'b1);
        step(makeRType(OP_CMP, 3, 1, 2), 1'b1);
        expectEq("result", result, 32'hFFFF_FFFE);
        step(makeRType(OP_OR, 4, 3, 0), 1'b1);
        expectEq("result", result, 32'd9);
        expectEq("flag", flag, 32'h6);       // N and borrow.
        step(makeRType(OP_CMP, 3, 1, 1), 1'b1);
        expectEq("result", result, '0);
        step(makeRType(OP_ADD, 4, 1, 2), 1'b1);
        expectEq("result", result, 32'd12);
        expectEq("flag", flag, 32'h1);
        step(makeRType(OP_OR, 5, 4, 0), 1'b1);
        expectEq("result", result, 32'd12);
        expectEq("flag", flag, 32'h1);
        step(makeIType(OP_ADDI, 9, 0, 16'd1), 1'b1);
        step(makeIType(OP_ADDI, 10, 0, 16'd31), 1'b1);
        step(makeRType(OP_SHL, 9, 9, 10), 1'b1);
        expectEq("result", result, 32'h8000_0000);
        step(makeRType(OP_CMP, 3, 9, 1), 1'b1);
        expectEq("result", result, 32'h7FFF_FFFB);
        step(makeRType(OP_OR, 4, 3, 0), 1'b1);
        expectEq("result", result, 32'd9);
        expectEq("flag", flag, 32'h8);       // Signed overflow only.
        finishTest("compare flags", base);

        base = directErrs + cmpErrs;
        step(makeIType(OP_ADDI, 11, 0, 16'hFFFF), 1'b1);
        step(makeRType(OP_ADDF, 12, 11, 1), 1'b1);
        expectEq("result", result, 32'd4);
        step(makeRType(OP_OR, 13, 12, 0), 1'b1);
        expectEq("result", result, 32'd4);
        expectEq("flag", flag, 32'h4);
        step(makeRType(OP_OR, 14, 31, 0), 1'b1);
        expectEq("result", result, 32'd4);
        step(makeRType(OP_ADDF, 31, 1, 2), 1'b1);
        expectEq("result", result, 32'd12);
        step(makeRType(OP_OR, 15, 31, 0), 1'b1);
        expectEq("result", result, '0);
        expectEq("flag", flag, '0);
        step(makeRType(OP_ADD, 31, 1, 1), 1'b1);
        step(makeRType(OP_OR, 15, 31, 0), 1'b1);
        expectEq("result", result, 32'hA);
        expectEq("flag", flag, 32'hA);
        finishTest("add with flags", base);

        base = directErrs + cmpErrs;
        for (n = 0; n < RANDOM_STEPS; n++) begin
            op = opTable[4'($urandom % 10)];
            if (op == OP_ADDI || op == OP_ORI) begin
                w = makeIType(op, $urandom % 32, $urandom % 32, 16'($urandom));
            end else begin
                w = makeRType(op, $urandom % 32, $urandom % 32, $urandom % 32);
            end
            step(w, ($urandom % 4) != 0);    // About one cycle in four idles.
        end
        step(makeRType(OP_OR, 0, 0, 0), 1'b0);
        finishTest("random stream", base);

        $display("Tests: 6, failed: %0d, errors: %0d", testsFailed, directErrs + cmpErrs);
        if (directErrs + cmpErrs == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
